// File: all.f
rtl/videoPkg.sv
rtl/rasterTiming.sv
rtl/videoRegs.sv
rtl/borderUnit.sv
rtl/videoTop.sv
verif/tbClock.sv
verif/tbChecker.sv
verif/tbTop.sv

// File: rtl/borderUnit.sv
// ================================================
// Border unit
// Mode-dependent border windows, registered border
// flags, combined border and pixel colour select
// ================================================

`timescale 1ns/1ps

module borderUnit (
	input  logic clk,
	input  logic rstN,
	input  logic [videoPkg::rasterXWidth-1:0] rasterX,
	input  logic [videoPkg::rasterYWidth-1:0] rasterY,
	input  logic den,
	input  logic rsel,
	input  logic csel,
	input  logic col80,
	input  logic [videoPkg::rasterYWidth-1:0] vBorderOff,
	input  logic [videoPkg::rasterYWidth-1:0] vBorderOn,
	input  logic [videoPkg::rasterXWidth-1:0] hBorderOff,
	input  logic [videoPkg::rasterXWidth-1:0] hBorderOn,
	input  logic [videoPkg::colorWidth-1:0] borderColor,
	input  logic [videoPkg::colorWidth-1:0] bgColor,
	output logic hBorder,
	output logic vBorder,
	output logic border,
	output logic [videoPkg::colorWidth-1:0] pixelColor
);

	// Window edges, held at the compare widths so that the sums wrap
	logic [videoPkg::rasterYWidth-1:0] vStart;
	logic [videoPkg::rasterYWidth-1:0] vEnd;
	logic [videoPkg::rasterXWidth-1:0] hStart;
	logic [videoPkg::rasterXWidth-1:0] hEnd;

	// Next values of the two flags
	logic vBorderNext;
	logic hBorderNext;

	// ================================================
	// Window edges
	// ================================================
	// Row select clear gives 24 rows, four lines narrower at each end
	always_comb begin
		if (rsel) begin
			vStart = vBorderOff;
			vEnd = vBorderOn;
		end else begin
			vStart = vBorderOff + 9'd4;
			vEnd = vBorderOn - 9'd4;
		end
	end

	// Column select clear gives 38 columns, 80-column mode stretches the right edge
	always_comb begin
		case ({col80, csel})
			2'b01: begin
				hStart = hBorderOff;
				hEnd = hBorderOn;
			end
			2'b00: begin
				hStart = hBorderOff + 11'd7;
				hEnd = hBorderOn - 11'd9;
			end
			2'b11: begin
				hStart = hBorderOff;
				hEnd = hBorderOn + 11'd320;
			end
			default: begin
				hStart = hBorderOff + 11'd7;
				hEnd = hBorderOn + 11'd312;
			end
		endcase
	end

	// The border opens only with the display enabled and inside the window
	assign vBorderNext = !(den && (rasterY >= vStart) && (rasterY <= vEnd));
	assign hBorderNext = !(den && (rasterX >= hStart) && (rasterX <= hEnd));

	// ================================================
	// Border flags
	// ================================================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			vBorder <= 1'b1;
			hBorder <= 1'b1;
		end else begin
			vBorder <= vBorderNext;
			hBorder <= hBorderNext;
		end
	end

	// Combined flag and colour follow the registered flags directly
	assign border = hBorder | vBorder;
	assign pixelColor = border ? borderColor : bgColor;

	// A disabled display closes both windows on the next cycle
	denClosesBorder: assert property (@(posedge clk) disable iff (!rstN)
		!den |=> (vBorder && hBorder));

endmodule

// File: rtl/rasterTiming.sv
// ================================================
// Raster timing
// Free-running dot and line counters for one frame
// ================================================

`timescale 1ns/1ps

module rasterTiming (
	input  logic clk,
	input  logic rstN,
	output logic [videoPkg::rasterXWidth-1:0] rasterX,
	output logic [videoPkg::rasterYWidth-1:0] rasterY
);

	// Line end and frame end markers
	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (rasterX == videoPkg::hLast);
	assign frameEnd = (rasterY == videoPkg::vLast);

	// ================================================
	// Horizontal dot counter
	// ================================================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			rasterX <= '0;
		end else if (lineEnd) begin
			rasterX <= '0;
		end else begin
			rasterX <= rasterX + 1'b1;
		end
	end

	// ================================================
	// Vertical line counter
	// ================================================
	// Advances only once per line, when the dot counter wraps
	always_ff @(posedge clk) begin
		if (!rstN) begin
			rasterY <= '0;
		end else if (lineEnd) begin
			if (frameEnd) begin
				rasterY <= '0;
			end else begin
				rasterY <= rasterY + 1'b1;
			end
		end
	end

	// Both counters stay inside the frame for the whole run
	rasterInFrame: assert property (@(posedge clk) disable iff (!rstN)
		(rasterX < videoPkg::hTotal) && (rasterY < videoPkg::vTotal));

endmodule

// File: rtl/videoPkg.sv
// ================================================
// Shared definitions for the video border section
// Frame sizes, field widths, register addresses,
// reset defaults and the control-word union
// ================================================

package videoPkg;

	// Frame geometry in dots per line and lines per frame
	localparam int hTotal = 520;
	localparam int vTotal = 312;

	// Field widths
	localparam int rasterXWidth = 11;
	localparam int rasterYWidth = 9;
	localparam int colorWidth = 4;
	localparam int regAddrWidth = 3;

	// Last counter values before the raster wraps
	localparam logic [rasterXWidth-1:0] hLast = rasterXWidth'(hTotal - 1);
	localparam logic [rasterYWidth-1:0] vLast = rasterYWidth'(vTotal - 1);

	// ================================================
	// Register map
	// ================================================
	localparam logic [regAddrWidth-1:0] addrCtrl1 = 3'd0;
	localparam logic [regAddrWidth-1:0] addrCtrl2 = 3'd1;
	localparam logic [regAddrWidth-1:0] addrVBorderOff = 3'd2;
	localparam logic [regAddrWidth-1:0] addrVBorderOn = 3'd3;
	localparam logic [regAddrWidth-1:0] addrHBorderOff = 3'd4;
	localparam logic [regAddrWidth-1:0] addrHBorderOn = 3'd5;
	localparam logic [regAddrWidth-1:0] addrBorderColor = 3'd6;
	localparam logic [regAddrWidth-1:0] addrBgColor = 3'd7;

	// Reset values, a 25-row by 40-column screen
	localparam logic [rasterYWidth-1:0] vBorderOffDefault = 9'd51;
	localparam logic [rasterYWidth-1:0] vBorderOnDefault = 9'd250;
	localparam logic [rasterXWidth-1:0] hBorderOffDefault = 11'd24;
	localparam logic [rasterXWidth-1:0] hBorderOnDefault = 11'd343;
	localparam logic [colorWidth-1:0] borderColorDefault = 4'd14;
	localparam logic [colorWidth-1:0] bgColorDefault = 4'd6;
	localparam logic denDefault = 1'b1;
	localparam logic rselDefault = 1'b1;
	localparam logic cselDefault = 1'b1;
	localparam logic col80Default = 1'b0;

	// Write data word, read through the view that matches the address
	typedef union packed {
		struct packed {
			logic [13:0] reserved;
			logic den;
			logic rsel;
		} ctrl1;
		struct packed {
			logic [13:0] reserved;
			logic col80;
			logic csel;
		} ctrl2;
	} ctrlWord;

endpackage

// File: rtl/videoRegs.sv
// ================================================
// Video register file
// Write-only control bits, border compare values
// and the border and background colours
// ================================================

`timescale 1ns/1ps

module videoRegs (
	input  logic clk,
	input  logic rstN,
	input  logic wrEn,
	input  logic [videoPkg::regAddrWidth-1:0] wrAddr,
	input  videoPkg::ctrlWord wrData,
	output logic den,
	output logic rsel,
	output logic csel,
	output logic col80,
	output logic [videoPkg::rasterYWidth-1:0] vBorderOff,
	output logic [videoPkg::rasterYWidth-1:0] vBorderOn,
	output logic [videoPkg::rasterXWidth-1:0] hBorderOff,
	output logic [videoPkg::rasterXWidth-1:0] hBorderOn,
	output logic [videoPkg::colorWidth-1:0] borderColor,
	output logic [videoPkg::colorWidth-1:0] bgColor
);

	// ================================================
	// Register write decode
	// ================================================
	// One register changes per strobe and every other register keeps its value
	always_ff @(posedge clk) begin
		if (!rstN) begin
			den <= videoPkg::denDefault;
			rsel <= videoPkg::rselDefault;
			csel <= videoPkg::cselDefault;
			col80 <= videoPkg::col80Default;
			vBorderOff <= videoPkg::vBorderOffDefault;
			vBorderOn <= videoPkg::vBorderOnDefault;
			hBorderOff <= videoPkg::hBorderOffDefault;
			hBorderOn <= videoPkg::hBorderOnDefault;
			borderColor <= videoPkg::borderColorDefault;
			bgColor <= videoPkg::bgColorDefault;
		end else if (wrEn) begin
			case (wrAddr)
				// First control word carries display enable and row select
				videoPkg::addrCtrl1: begin
					den <= wrData.ctrl1.den;
					rsel <= wrData.ctrl1.rsel;
				end
				// Second control word carries column select and 80-column mode
				videoPkg::addrCtrl2: begin
					csel <= wrData.ctrl2.csel;
					col80 <= wrData.ctrl2.col80;
				end
				// Vertical compare values use the low line-number bits
				videoPkg::addrVBorderOff: vBorderOff <= wrData[videoPkg::rasterYWidth-1:0];
				videoPkg::addrVBorderOn:  vBorderOn <= wrData[videoPkg::rasterYWidth-1:0];
				// Horizontal compare values use the low dot-position bits
				videoPkg::addrHBorderOff: hBorderOff <= wrData[videoPkg::rasterXWidth-1:0];
				videoPkg::addrHBorderOn:  hBorderOn <= wrData[videoPkg::rasterXWidth-1:0];
				// Colour indices
				videoPkg::addrBorderColor: borderColor <= wrData[videoPkg::colorWidth-1:0];
				videoPkg::addrBgColor:     bgColor <= wrData[videoPkg::colorWidth-1:0];
				default: begin
					// Every address is mapped, nothing to do here
				end
			endcase
		end
	end

endmodule

// File: rtl/videoTop.sv
// ================================================
// Video border section top level
// Raster timing, register file and border unit
// ================================================

`timescale 1ns/1ps

module videoTop (
	input  logic clk,
	input  logic rstN,
	input  logic wrEn,
	input  logic [videoPkg::regAddrWidth-1:0] wrAddr,
	input  videoPkg::ctrlWord wrData,
	output logic [videoPkg::rasterXWidth-1:0] rasterX,
	output logic [videoPkg::rasterYWidth-1:0] rasterY,
	output logic hBorder,
	output logic vBorder,
	output logic border,
	output logic [videoPkg::colorWidth-1:0] pixelColor
);

	// Register file outputs into the border unit
	logic den;
	logic rsel;
	logic csel;
	logic col80;
	logic [videoPkg::rasterYWidth-1:0] vBorderOff;
	logic [videoPkg::rasterYWidth-1:0] vBorderOn;
	logic [videoPkg::rasterXWidth-1:0] hBorderOff;
	logic [videoPkg::rasterXWidth-1:0] hBorderOn;
	logic [videoPkg::colorWidth-1:0] borderColor;
	logic [videoPkg::colorWidth-1:0] bgColor;

	// ================================================
	// Instances
	// ================================================
	rasterTiming uTiming (
		.clk(clk), .rstN(rstN),
		.rasterX(rasterX), .rasterY(rasterY)
	);

	videoRegs uRegs (
		.clk(clk), .rstN(rstN),
		.wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
		.den(den), .rsel(rsel), .csel(csel), .col80(col80),
		.vBorderOff(vBorderOff), .vBorderOn(vBorderOn),
		.hBorderOff(hBorderOff), .hBorderOn(hBorderOn),
		.borderColor(borderColor), .bgColor(bgColor)
	);

	// Flags lag the raster by one cycle
	borderUnit uBorder (
		.clk(clk), .rstN(rstN),
		.rasterX(rasterX), .rasterY(rasterY),
		.den(den), .rsel(rsel), .csel(csel), .col80(col80),
		.vBorderOff(vBorderOff), .vBorderOn(vBorderOn),
		.hBorderOff(hBorderOff), .hBorderOn(hBorderOn),
		.borderColor(borderColor), .bgColor(bgColor),
		.hBorder(hBorder), .vBorder(vBorder),
		.border(border), .pixelColor(pixelColor)
	);

endmodule

// File: run.sh
#!/bin/sh
# Build and run the border section testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tbTop -o tbSim
./obj_dir/tbSim > sim.log 2>&1 || true
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log || ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation passed"

// File: verif/tbChecker.sv
// ================================================
// Testbench checker
// Reference model for border flags and pixel colour,
// raster wrap checks and per-test result lines
// ================================================

`timescale 1ns/1ps

module tbChecker (
	input  logic clk,
	input  logic rstN,
	input  int testId,
	input  logic testDone,
	input  logic [videoPkg::rasterXWidth-1:0] rasterX,
	input  logic [videoPkg::rasterYWidth-1:0] rasterY,
	input  logic hBorder,
	input  logic vBorder,
	input  logic border,
	input  logic [videoPkg::colorWidth-1:0] pixelColor,
	input  logic den,
	input  logic rsel,
	input  logic csel,
	input  logic col80,
	input  logic [videoPkg::rasterYWidth-1:0] vBorderOff,
	input  logic [videoPkg::rasterYWidth-1:0] vBorderOn,
	input  logic [videoPkg::rasterXWidth-1:0] hBorderOff,
	input  logic [videoPkg::rasterXWidth-1:0] hBorderOn,
	input  logic [videoPkg::colorWidth-1:0] borderColor,
	input  logic [videoPkg::colorWidth-1:0] bgColor,
	output int errorCount,
	output int failedTests
);

	// Raster position and settings seen on the previous falling edge
	logic [videoPkg::rasterXWidth-1:0] lastX;
	logic [videoPkg::rasterYWidth-1:0] lastY;
	logic lastDen;
	logic lastRsel;
	logic lastCsel;
	logic lastCol80;
	logic [videoPkg::rasterYWidth-1:0] lastVOff;
	logic [videoPkg::rasterYWidth-1:0] lastVOn;
	logic [videoPkg::rasterXWidth-1:0] lastHOff;
	logic [videoPkg::rasterXWidth-1:0] lastHOn;
	logic lastValid = 1'b0;
	logic [6:0] expected;
	logic [videoPkg::rasterXWidth-1:0] nextX;
	logic [videoPkg::rasterYWidth-1:0] nextY;
	int testErrors = 0;
	int errors = 0;
	int failed = 0;

	assign errorCount = errors;
	assign failedTests = failed;

	function automatic string testName(input int id);
		case (id)
			1: return "resetDefaults";
			2: return "narrowWindows";
			3: return "col80Mode";
			4: return "displayDisabled";
			5: return "coloursAndDecode";
			default: return "unknown";
		endcase
	endfunction

	// ================================================
	// Reference model
	// ================================================
	// Returns hBorder, vBorder, border and the pixel colour, in that order
	function automatic logic [6:0] expectOut(
		input logic [10:0] x, input logic [8:0] y,
		input logic d, input logic r, input logic c, input logic c80,
		input logic [8:0] vOff, input logic [8:0] vOn,
		input logic [10:0] hOff, input logic [10:0] hOn,
		input logic [3:0] borderCol, input logic [3:0] bgCol);
		logic [8:0] vLo;
		logic [8:0] vHi;
		logic [10:0] hLo;
		logic [10:0] hHi;
		logic vB;
		logic hB;
		vLo = r ? vOff : vOff + 9'd4;
		vHi = r ? vOn : vOn - 9'd4;
		hLo = c ? hOff : hOff + 11'd7;
		// 80-column mode moves only the right edge
		if (c80) begin
			hHi = c ? hOn + 11'd320 : hOn + 11'd312;
		end else begin
			hHi = c ? hOn : hOn - 11'd9;
		end
		vB = !(d && (y >= vLo) && (y <= vHi));
		hB = !(d && (x >= hLo) && (x <= hHi));
		return {hB, vB, hB | vB, (hB | vB) ? borderCol : bgCol};
	endfunction

	task automatic reportMismatch(input string what, input logic [10:0] exp,
		input logic [10:0] act);
		testErrors++;
		// Only the first few lines per test, the count keeps going
		if (testErrors <= 10) begin
			$display("Error %s: %s expected %0h actual %0h", testName(testId), what, exp, act);
		end
	endtask

	// ================================================
	// Compare on every falling edge
	// ================================================
	always @(negedge clk) begin
		if (!rstN) begin
			// Flags are unknown before the first rising edge in reset
			if (lastValid && ({hBorder, vBorder, border} !== 3'b111)) begin
				reportMismatch("flags in reset", 11'b111, 11'({hBorder, vBorder, border}));
			end
			lastValid = 1'b1;
		end else if (lastValid) begin
			// Flags come from the last cycle, the colour registers from this one
			expected = expectOut(lastX, lastY, lastDen, lastRsel, lastCsel, lastCol80,
				lastVOff, lastVOn, lastHOff, lastHOn, borderColor, bgColor);
			if ({hBorder, vBorder, border, pixelColor} !== expected) begin
				reportMismatch("flags and colour", 11'(expected),
					11'({hBorder, vBorder, border, pixelColor}));
			end
			nextX = (lastX == 11'(videoPkg::hTotal - 1)) ? '0 : lastX + 11'd1;
			nextY = lastY;
			if (lastX == 11'(videoPkg::hTotal - 1)) begin
				nextY = (lastY == 9'(videoPkg::vTotal - 1)) ? '0 : lastY + 9'd1;
			end
			if (rasterX !== nextX) begin
				reportMismatch("rasterX", nextX, rasterX);
			end
			if (rasterY !== nextY) begin
				reportMismatch("rasterY", 11'(nextY), 11'(rasterY));
			end
		end
		if (testDone) begin
			if (testErrors == 0) begin
				$display("Test %0d %s: passed", testId, testName(testId));
			end else begin
				$display("Test %0d %s: failed, %0d mismatches", testId, testName(testId),
					testErrors);
				failed++;
			end
			errors += testErrors;
			testErrors = 0;
		end
		lastX = rasterX;
		lastY = rasterY;
		lastDen = den;
		lastRsel = rsel;
		lastCsel = csel;
		lastCol80 = col80;
		lastVOff = vBorderOff;
		lastVOn = vBorderOn;
		lastHOff = hBorderOff;
		lastHOn = hBorderOn;
	end

endmodule

// File: verif/tbClock.sv
// ================================================
// Testbench clock and reset generator
// 100 ns clock, reset held low for three cycles
// ================================================

`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rstN
);

	// Free-running clock with a 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Reset covers three rising edges and lifts on a falling edge
	initial begin
		rstN = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN <= 1'b1;
	end

endmodule

// File: verif/tbTop.sv
// ================================================
// Testbench top for the video border section
// DUT, clock, checker, register writes, test
// sequence, timeout and final report
// ================================================

`timescale 1ns/1ps

module tbTop;

	localparam int frameCycles = videoPkg::hTotal * videoPkg::vTotal;
	localparam int cycleLimit = 6 * frameCycles + 100;
	localparam int testCount = 5;

	logic clk;
	logic rstN;
	logic wrEn;
	logic [videoPkg::regAddrWidth-1:0] wrAddr;
	videoPkg::ctrlWord wrData;
	logic [videoPkg::rasterXWidth-1:0] rasterX;
	logic [videoPkg::rasterYWidth-1:0] rasterY;
	logic hBorder;
	logic vBorder;
	logic border;
	logic [videoPkg::colorWidth-1:0] pixelColor;

	// Shadow copy of the register file, updated on the write edge
	logic den = videoPkg::denDefault;
	logic rsel = videoPkg::rselDefault;
	logic csel = videoPkg::cselDefault;
	logic col80 = videoPkg::col80Default;
	logic [videoPkg::rasterYWidth-1:0] vBorderOff = videoPkg::vBorderOffDefault;
	logic [videoPkg::rasterYWidth-1:0] vBorderOn = videoPkg::vBorderOnDefault;
	logic [videoPkg::rasterXWidth-1:0] hBorderOff = videoPkg::hBorderOffDefault;
	logic [videoPkg::rasterXWidth-1:0] hBorderOn = videoPkg::hBorderOnDefault;
	logic [videoPkg::colorWidth-1:0] borderColor = videoPkg::borderColorDefault;
	logic [videoPkg::colorWidth-1:0] bgColor = videoPkg::bgColorDefault;

	int testId = 1;
	logic testDone = 1'b0;
	int errorCount;
	int failedTests;
	int seed = 65;
	int cycles = 0;

	tbClock clockGen (.clk(clk), .rstN(rstN));
	videoTop u_videoTop (.*);
	tbChecker checkUnit (.*);

	function automatic videoPkg::ctrlWord ctrl1Word(input logic d, input logic r,
		input logic fill);
		videoPkg::ctrlWord w;
		w.ctrl1.reserved = {14{fill}};
		w.ctrl1.den = d;
		w.ctrl1.rsel = r;
		return w;
	endfunction

	function automatic videoPkg::ctrlWord ctrl2Word(input logic c80, input logic c,
		input logic fill);
		videoPkg::ctrlWord w;
		w.ctrl2.reserved = {14{fill}};
		w.ctrl2.col80 = c80;
		w.ctrl2.csel = c;
		return w;
	endfunction

	// One write strobe, driven on a falling edge and taken on the next rising edge
	task automatic writeReg(input logic [videoPkg::regAddrWidth-1:0] addr,
		input videoPkg::ctrlWord data);
		wrEn <= 1'b1;
		wrAddr <= addr;
		wrData <= data;
		@(posedge clk);
		case (addr)
			videoPkg::addrCtrl1: begin
				den = data.ctrl1.den;
				rsel = data.ctrl1.rsel;
			end
			videoPkg::addrCtrl2: begin
				csel = data.ctrl2.csel;
				col80 = data.ctrl2.col80;
			end
			videoPkg::addrVBorderOff: vBorderOff = data[8:0];
			videoPkg::addrVBorderOn: vBorderOn = data[8:0];
			videoPkg::addrHBorderOff: hBorderOff = data[10:0];
			videoPkg::addrHBorderOn: hBorderOn = data[10:0];
			videoPkg::addrBorderColor: borderColor = data[3:0];
			videoPkg::addrBgColor: bgColor = data[3:0];
		endcase
		@(negedge clk);
		wrEn <= 1'b0;
	endtask

	// Pulses the test end for one cycle, then moves on to the next test
	task automatic endTest(input int nextId);
		testDone <= 1'b1;
		@(negedge clk);
		testDone <= 1'b0;
		testId <= nextId;
	endtask

	// ================================================
	// Test sequence
	// ================================================
	initial begin
		wrEn = 1'b0;
		wrAddr = '0;
		wrData = '0;
		@(posedge rstN);
		@(negedge clk);
		// Default 25-row, 40-column window over a full frame
		repeat (frameCycles) @(negedge clk);
		endTest(2);
		// 24 rows and 38 columns
		writeReg(videoPkg::addrCtrl1, ctrl1Word(1'b1, 1'b0, 1'b0));
		writeReg(videoPkg::addrCtrl2, ctrl2Word(1'b0, 1'b0, 1'b0));
		repeat (frameCycles) @(negedge clk);
		endTest(3);
		// Random compare values, then both column selects in 80-column mode
		writeReg(videoPkg::addrVBorderOff, 16'(30 + ($random(seed) & 31)));
		writeReg(videoPkg::addrVBorderOn, 16'(200 + ($random(seed) & 63)));
		writeReg(videoPkg::addrHBorderOff, 16'(10 + ($random(seed) & 63)));
		writeReg(videoPkg::addrHBorderOn, 16'(100 + ($random(seed) & 127)));
		writeReg(videoPkg::addrCtrl2, ctrl2Word(1'b1, 1'b1, 1'b0));
		repeat (frameCycles / 2) @(negedge clk);
		writeReg(videoPkg::addrCtrl2, ctrl2Word(1'b1, 1'b0, 1'b0));
		repeat (frameCycles / 2) @(negedge clk);
		endTest(4);
		// Display off keeps the border colour everywhere
		writeReg(videoPkg::addrCtrl1, ctrl1Word(1'b0, 1'b1, 1'b0));
		repeat (frameCycles) @(negedge clk);
		endTest(5);
		// Random distinct colours, and reserved bits set in each control view
		writeReg(videoPkg::addrBorderColor, 16'($random(seed) & 15));
		writeReg(videoPkg::addrBgColor, 16'(borderColor ^ 4'(1 + ($random(seed) & 14))));
		writeReg(videoPkg::addrCtrl2, ctrl2Word(1'b0, 1'b1, 1'b0));
		// Each control write carries the opposite bits of the other view's fields
		writeReg(videoPkg::addrCtrl1, ctrl1Word(1'b1, 1'b0, 1'b1));
		repeat (frameCycles / 2) @(negedge clk);
		writeReg(videoPkg::addrCtrl2, ctrl2Word(1'b0, 1'b1, 1'b1));
		repeat (frameCycles / 2) @(negedge clk);
		endTest(0);
		@(negedge clk);
		$display("Tests run %0d, tests failed %0d, mismatches %0d", testCount, failedTests,
			errorCount);
		if (failedTests == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Run limit of six frames plus a margin for the writes
	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

endmodule
